// ==== ex_pkg.sv ====
// shared widths, opcodes, zones, start-of-flow tags and trap causes for the execute stage
package ex_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      regaddr_t;
    typedef logic [2:0]      funct3_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    // branch compares, same codes as the branch funct3 field
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    // where a committed result goes
    typedef enum logic [1:0] {
        zone_none    = 2'd0,
        zone_regfile = 2'd1,
        zone_loadq   = 2'd2,
        zone_storeq  = 2'd3
    } zone_e;

    typedef enum logic {
        sofid_run  = 1'b0,
        sofid_jump = 1'b1
    } sofid_e;

    // exception codes as in the privileged spec
    typedef enum logic [3:0] {
        cause_misaligned_fetch = 4'd0,
        cause_fetch_fault      = 4'd1,
        cause_illegal_ins      = 4'd2,
        cause_misaligned_load  = 4'd4,
        cause_misaligned_store = 4'd6,
        cause_ecall            = 4'd11
    } trap_cause_e;

    localparam funct3_t funct3_half = 3'b001;
    localparam funct3_t funct3_word = 3'b010;

endpackage

// ==== ex_op_if.sv ====
// registered instruction bus between the issue register and the commit controller
`timescale 1ns/1ps

interface ex_op_if;

    // qualification
    logic                valid;
    logic                run;
    ex_pkg::zone_e       zone;

    // decoded flags
    logic                cond;
    logic                jump;
    logic                link;
    logic                ecall;
    logic                ferr;
    logic                uerr;

    // payload
    ex_pkg::funct3_t     funct3;
    ex_pkg::regaddr_t    regd_addr;
    ex_pkg::xlen_t       pc;
    ex_pkg::xlen_t       pc_inc;
    ex_pkg::xlen_t       regs2_data;

    modport issue (
        output valid, run, zone,
        output cond, jump, link, ecall, ferr, uerr,
        output funct3, regd_addr, pc, pc_inc, regs2_data
    );

    modport commit (
        input  valid, run, zone,
        input  cond, jump, link, ecall, ferr, uerr,
        input  funct3, regd_addr, pc, pc_inc, regs2_data
    );

endinterface

// ==== ex_alu.sv ====
// registered alu and branch comparator
`timescale 1ns/1ps

module ex_alu (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              en_i,
    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::xlen_t     left_i,
    input  ex_pkg::xlen_t     right_i,
    input  ex_pkg::cmp_op_e   cmp_op_i,
    input  ex_pkg::xlen_t     cmp_left_i,
    input  ex_pkg::xlen_t     cmp_right_i,
    output ex_pkg::xlen_t     result_o,
    output logic              cmp_o
);

    ex_pkg::xlen_t result_d;
    ex_pkg::xlen_t result_q;
    logic          cmp_d;
    logic          cmp_q;
    logic          cmp_eq;
    logic          cmp_lt;
    logic          cmp_ltu;

    //--------------------------------------------------------------------------
    // operation
    //--------------------------------------------------------------------------
    always_comb begin
        case (op_i)
            ex_pkg::alu_add:  result_d = left_i + right_i;
            ex_pkg::alu_sub:  result_d = left_i - right_i;
            ex_pkg::alu_and:  result_d = left_i & right_i;
            ex_pkg::alu_or:   result_d = left_i | right_i;
            ex_pkg::alu_xor:  result_d = left_i ^ right_i;
            ex_pkg::alu_sll:  result_d = left_i << right_i[4:0];
            ex_pkg::alu_srl:  result_d = left_i >> right_i[4:0];
            ex_pkg::alu_sra:  result_d = ex_pkg::xlen_t'($signed(left_i) >>> right_i[4:0]);
            ex_pkg::alu_slt:  result_d = ex_pkg::xlen_t'($signed(left_i) < $signed(right_i));
            ex_pkg::alu_sltu: result_d = ex_pkg::xlen_t'(left_i < right_i);
            default:          result_d = '0;
        endcase
    end

    //--------------------------------------------------------------------------
    // branch compare
    //--------------------------------------------------------------------------
    assign cmp_eq  = (cmp_left_i == cmp_right_i);
    assign cmp_lt  = ($signed(cmp_left_i) < $signed(cmp_right_i));
    assign cmp_ltu = (cmp_left_i < cmp_right_i);

    always_comb begin
        case (cmp_op_i)
            ex_pkg::cmp_beq:  cmp_d = cmp_eq;
            ex_pkg::cmp_bne:  cmp_d = ~cmp_eq;
            ex_pkg::cmp_blt:  cmp_d = cmp_lt;
            ex_pkg::cmp_bge:  cmp_d = ~cmp_lt;
            ex_pkg::cmp_bltu: cmp_d = cmp_ltu;
            ex_pkg::cmp_bgeu: cmp_d = ~cmp_ltu;
            // funct3 codes 2 and 3 are not branches
            default:          cmp_d = 1'b0;
        endcase
    end

    // held with the stage register
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            result_q <= result_d;
            cmp_q    <= cmp_d;
        end
    end

    assign result_o = result_q;
    assign cmp_o    = cmp_q;

    a_op_known: assert property (@(posedge clk_i) disable iff (reset_i)
        en_i |-> op_i inside {ex_pkg::alu_add, ex_pkg::alu_sub, ex_pkg::alu_and,
                              ex_pkg::alu_or, ex_pkg::alu_xor, ex_pkg::alu_sll,
                              ex_pkg::alu_srl, ex_pkg::alu_sra, ex_pkg::alu_slt,
                              ex_pkg::alu_sltu});

endmodule

// ==== ex_issue_reg.sv ====
// execute stage register with pc increment and start-of-flow tracker
`timescale 1ns/1ps

module ex_issue_reg (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               stage_en_i,
    input  logic               redirect_i,
    // decode side
    input  logic               ids_valid_i,
    input  ex_pkg::sofid_e     ids_sofid_i,
    input  logic [1:0]         ids_ins_size_i,
    input  logic               ids_ins_uerr_i,
    input  logic               ids_ins_ferr_i,
    input  logic               ids_jump_i,
    input  logic               ids_ecall_i,
    input  logic               ids_cond_i,
    input  logic               ids_link_i,
    input  ex_pkg::zone_e      ids_zone_i,
    input  ex_pkg::xlen_t      ids_pc_i,
    input  ex_pkg::xlen_t      ids_regs2_data_i,
    input  ex_pkg::regaddr_t   ids_regd_addr_i,
    input  ex_pkg::funct3_t    ids_funct3_i,
    // to commit
    ex_op_if.issue             op
);

    ex_pkg::sofid_e sofid_q;
    logic           valid_q;

    //--------------------------------------------------------------------------
    // start-of-flow tracker
    //--------------------------------------------------------------------------
    // a redirect drops everything until fetch marks the new flow
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sofid_q <= ex_pkg::sofid_run;
        end else if (stage_en_i) begin
            if (redirect_i) begin
                sofid_q <= ex_pkg::sofid_jump;
            end else if (ids_valid_i && ids_sofid_i == sofid_q) begin
                sofid_q <= ex_pkg::sofid_run;
            end
        end
    end

    assign op.run = (sofid_q == ex_pkg::sofid_run);

    //--------------------------------------------------------------------------
    // stage register
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (stage_en_i) begin
            valid_q <= ids_valid_i;
        end
    end

    assign op.valid = valid_q;

    // payload, no reset needed
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            op.zone       <= ids_zone_i;
            op.cond       <= ids_cond_i;
            op.jump       <= ids_jump_i;
            op.link       <= ids_link_i;
            op.ecall      <= ids_ecall_i;
            op.ferr       <= ids_ins_ferr_i;
            op.uerr       <= ids_ins_uerr_i;
            op.funct3     <= ids_funct3_i;
            op.regd_addr  <= ids_regd_addr_i;
            op.pc         <= ids_pc_i;
            // size counts half-words
            op.pc_inc     <= ids_pc_i + ex_pkg::xlen_t'({ids_ins_size_i, 1'b0});
            op.regs2_data <= ids_regs2_data_i;
        end
    end

    a_valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
        !stage_en_i |=> $stable(op.valid));

endmodule

// ==== ex_commit_ctrl.sv ====
// exception checks, commit qualification, stall control and commit output muxes
`timescale 1ns/1ps

module ex_commit_ctrl #(
    parameter ex_pkg::xlen_t TRAP_VEC       = 32'h0000_0100,
    parameter bit            HAS_COMPRESSED = 1'b0
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    ex_op_if.commit              op,
    input  ex_pkg::xlen_t        alu_result_i,
    input  logic                 alu_cmp_i,
    input  logic                 lsq_full_i,
    output logic                 stage_en_o,
    output logic                 redirect_o,
    output logic                 trap_o,
    output ex_pkg::trap_cause_e  trap_cause_o,
    output ex_pkg::xlen_t        jump_addr_o,
    output logic                 regd_wr_o,
    output logic                 regd_cncl_load_o,
    output logic                 lq_wr_o,
    output logic                 sq_wr_o,
    output ex_pkg::xlen_t        regd_data_o
);

    logic is_load;
    logic is_store;
    logic is_reg;
    logic misaligned;
    logic excp_maif;
    logic excp_mala;
    logic excp_masa;
    logic excp_any;
    logic trap;
    logic commit;
    logic stall;

    assign is_load  = (op.zone == ex_pkg::zone_loadq);
    assign is_store = (op.zone == ex_pkg::zone_storeq);
    assign is_reg   = (op.zone == ex_pkg::zone_regfile);

    //--------------------------------------------------------------------------
    // exception checks
    //--------------------------------------------------------------------------
    // access address is the alu result
    assign misaligned = (op.funct3 == ex_pkg::funct3_half && alu_result_i[0]) ||
                        (op.funct3 == ex_pkg::funct3_word && |alu_result_i[1:0]);
    assign excp_mala  = is_load & misaligned;
    assign excp_masa  = is_store & misaligned;
    assign excp_maif  = op.jump & (HAS_COMPRESSED ? alu_result_i[0] : |alu_result_i[1:0]);
    assign excp_any   = op.ferr | op.uerr | excp_maif | op.ecall | excp_mala | excp_masa;

    always_comb begin
        if (op.ferr) begin
            trap_cause_o = ex_pkg::cause_fetch_fault;
        end else if (op.uerr) begin
            trap_cause_o = ex_pkg::cause_illegal_ins;
        end else if (excp_maif) begin
            trap_cause_o = ex_pkg::cause_misaligned_fetch;
        end else if (op.ecall) begin
            trap_cause_o = ex_pkg::cause_ecall;
        end else if (excp_mala) begin
            trap_cause_o = ex_pkg::cause_misaligned_load;
        end else begin
            trap_cause_o = ex_pkg::cause_misaligned_store;
        end
    end

    //--------------------------------------------------------------------------
    // commit and stall
    //--------------------------------------------------------------------------
    assign trap   = op.valid & op.run & excp_any;
    assign commit = op.valid & op.run & (~op.cond | alu_cmp_i) & ~trap;

    // hold a load or store until the queue has room
    assign stall      = commit & lsq_full_i & (is_load | is_store);
    assign stage_en_o = ~stall;

    assign redirect_o       = stage_en_o & ((commit & op.jump) | trap);
    assign trap_o           = stage_en_o & trap;
    assign regd_wr_o        = stage_en_o & commit & is_reg;
    assign lq_wr_o          = stage_en_o & commit & is_load;
    assign sq_wr_o          = stage_en_o & commit & is_store;
    // tells the register file a pending load will not return
    assign regd_cncl_load_o = stage_en_o & op.valid & is_load & ~commit;

    //--------------------------------------------------------------------------
    // output muxes
    //--------------------------------------------------------------------------
    assign jump_addr_o = trap ? TRAP_VEC : alu_result_i;
    assign regd_data_o = op.link ? op.pc_inc : alu_result_i;

    a_trap_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
        trap_o |-> !(regd_wr_o || lq_wr_o || sq_wr_o));

endmodule

// ==== ex_stage_top.sv ====
// execute stage top level with issue register, alu and commit controller
`timescale 1ns/1ps

module ex_stage_top #(
    parameter ex_pkg::xlen_t TRAP_VEC       = 32'h0000_0100,
    parameter bit            HAS_COMPRESSED = 1'b0
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // fetch redirect
    output logic                 pfu_jump_o,
    output ex_pkg::xlen_t        pfu_jump_addr_o,
    // decode side
    input  logic                 ids_valid_i,
    output logic                 ids_stall_o,
    input  ex_pkg::sofid_e       ids_sofid_i,
    input  logic [1:0]           ids_ins_size_i,
    input  logic                 ids_ins_uerr_i,
    input  logic                 ids_ins_ferr_i,
    input  logic                 ids_jump_i,
    input  logic                 ids_ecall_i,
    input  logic                 ids_cond_i,
    input  logic                 ids_link_i,
    input  ex_pkg::zone_e        ids_zone_i,
    input  ex_pkg::xlen_t        ids_pc_i,
    input  ex_pkg::alu_op_e      ids_alu_op_i,
    input  ex_pkg::xlen_t        ids_operand_left_i,
    input  ex_pkg::xlen_t        ids_operand_right_i,
    input  ex_pkg::xlen_t        ids_regs1_data_i,
    input  ex_pkg::xlen_t        ids_cmp_right_i,
    input  ex_pkg::xlen_t        ids_regs2_data_i,
    input  ex_pkg::regaddr_t     ids_regd_addr_i,
    input  ex_pkg::funct3_t      ids_funct3_i,
    // write-back
    output logic                 ids_regd_wr_o,
    output logic                 ids_regd_cncl_load_o,
    output ex_pkg::regaddr_t     ids_regd_addr_o,
    output ex_pkg::xlen_t        ids_regd_data_o,
    // load/store queue
    input  logic                 lsq_full_i,
    output logic                 lsq_lq_wr_o,
    output logic                 lsq_sq_wr_o,
    output ex_pkg::funct3_t      lsq_funct3_o,
    output ex_pkg::regaddr_t     lsq_regd_addr_o,
    output ex_pkg::xlen_t        lsq_regs2_data_o,
    output ex_pkg::xlen_t        lsq_addr_o,
    // exceptions
    output logic                 trap_o,
    output ex_pkg::trap_cause_e  trap_cause_o
);

    logic          stage_en;
    logic          redirect;
    ex_pkg::xlen_t alu_result;
    logic          alu_cmp;

    ex_op_if op_bus ();

    ex_issue_reg u_issue_reg (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .stage_en_i       (stage_en),
        .redirect_i       (redirect),
        .ids_valid_i      (ids_valid_i),
        .ids_sofid_i      (ids_sofid_i),
        .ids_ins_size_i   (ids_ins_size_i),
        .ids_ins_uerr_i   (ids_ins_uerr_i),
        .ids_ins_ferr_i   (ids_ins_ferr_i),
        .ids_jump_i       (ids_jump_i),
        .ids_ecall_i      (ids_ecall_i),
        .ids_cond_i       (ids_cond_i),
        .ids_link_i       (ids_link_i),
        .ids_zone_i       (ids_zone_i),
        .ids_pc_i         (ids_pc_i),
        .ids_regs2_data_i (ids_regs2_data_i),
        .ids_regd_addr_i  (ids_regd_addr_i),
        .ids_funct3_i     (ids_funct3_i),
        .op               (op_bus.issue)
    );

    // compare type comes straight from funct3
    ex_alu u_alu (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .en_i        (stage_en),
        .op_i        (ids_alu_op_i),
        .left_i      (ids_operand_left_i),
        .right_i     (ids_operand_right_i),
        .cmp_op_i    (ex_pkg::cmp_op_e'(ids_funct3_i)),
        .cmp_left_i  (ids_regs1_data_i),
        .cmp_right_i (ids_cmp_right_i),
        .result_o    (alu_result),
        .cmp_o       (alu_cmp)
    );

    ex_commit_ctrl #(
        .TRAP_VEC       (TRAP_VEC),
        .HAS_COMPRESSED (HAS_COMPRESSED)
    ) u_commit_ctrl (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .op               (op_bus.commit),
        .alu_result_i     (alu_result),
        .alu_cmp_i        (alu_cmp),
        .lsq_full_i       (lsq_full_i),
        .stage_en_o       (stage_en),
        .redirect_o       (redirect),
        .trap_o           (trap_o),
        .trap_cause_o     (trap_cause_o),
        .jump_addr_o      (pfu_jump_addr_o),
        .regd_wr_o        (ids_regd_wr_o),
        .regd_cncl_load_o (ids_regd_cncl_load_o),
        .lq_wr_o          (lsq_lq_wr_o),
        .sq_wr_o          (lsq_sq_wr_o),
        .regd_data_o      (ids_regd_data_o)
    );

    assign pfu_jump_o       = redirect;
    assign ids_stall_o      = ~stage_en;
    assign ids_regd_addr_o  = op_bus.regd_addr;
    assign lsq_funct3_o     = op_bus.funct3;
    assign lsq_regd_addr_o  = op_bus.regd_addr;
    assign lsq_regs2_data_o = op_bus.regs2_data;
    assign lsq_addr_o       = alu_result;

endmodule

// ==== tb_ex_model.svh ====
// reference model of the execute stage and the galois lfsr behind the random stimulus
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

logic [31:0] lfsr_state = 32'd55654;

// right-shifting galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return bits;
endfunction

// signed order through a flipped sign bit
function automatic logic less_signed(input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic ex_pkg::xlen_t expected_alu(input ex_pkg::alu_op_e op,
                                               input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    ex_pkg::xlen_t fill;
    // sign bits shifted in from the left
    fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;
    case (op)
        ex_pkg::alu_add:  return a + b;
        ex_pkg::alu_sub:  return a + ~b + 32'd1;
        ex_pkg::alu_and:  return a & b;
        ex_pkg::alu_or:   return a | b;
        ex_pkg::alu_xor:  return a ^ b;
        ex_pkg::alu_sll:  return a << b[4:0];
        ex_pkg::alu_srl:  return a >> b[4:0];
        ex_pkg::alu_sra:  return (a >> b[4:0]) | fill;
        ex_pkg::alu_slt:  return {31'd0, less_signed(a, b)};
        ex_pkg::alu_sltu: return {31'd0, a < b};
        default:          return '0;
    endcase
endfunction

// branch compare keyed by funct3, the two non-branch codes never hold
function automatic logic branch_holds(input ex_pkg::funct3_t f3, input ex_pkg::xlen_t a,
                                      input ex_pkg::xlen_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return less_signed(a, b);
        3'b101:  return !less_signed(a, b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

//--------------------------------------------------------------------------
// stage register as the model sees it, m_run is the start-of-flow state
//--------------------------------------------------------------------------
logic                m_valid;
logic                m_run;
ex_pkg::zone_e       m_zone;
logic                m_cond, m_jump, m_link, m_ecall, m_ferr, m_uerr;
ex_pkg::funct3_t     m_funct3;
ex_pkg::regaddr_t    m_regd_addr;
ex_pkg::xlen_t       m_link_addr;
ex_pkg::xlen_t       m_regs2;
ex_pkg::xlen_t       m_result;
logic                m_cmp;

// expected outputs for the instruction held this cycle
logic                e_trap, e_commit, e_en, e_jump;
logic                e_regd_wr, e_lq_wr, e_sq_wr, e_cncl;
ex_pkg::trap_cause_e e_cause;

task automatic predict_outputs(input logic full);
    logic is_ld;
    logic is_st;
    logic misal;
    logic maif;
    is_ld = (m_zone == ex_pkg::zone_loadq);
    is_st = (m_zone == ex_pkg::zone_storeq);
    misal = (m_funct3 == ex_pkg::funct3_half) ? m_result[0] :
            (m_funct3 == ex_pkg::funct3_word) ? (m_result[1:0] != 2'b00) : 1'b0;
    // no compressed code, so jump targets need word alignment
    maif  = m_jump && (m_result[1:0] != 2'b00);
    e_cause = m_ferr  ? ex_pkg::cause_fetch_fault :
              m_uerr  ? ex_pkg::cause_illegal_ins :
              maif    ? ex_pkg::cause_misaligned_fetch :
              m_ecall ? ex_pkg::cause_ecall :
              is_ld   ? ex_pkg::cause_misaligned_load : ex_pkg::cause_misaligned_store;
    e_trap    = m_valid && m_run &&
                (m_ferr || m_uerr || maif || m_ecall || ((is_ld || is_st) && misal));
    e_commit  = m_valid && m_run && (!m_cond || m_cmp) && !e_trap;
    e_en      = !(e_commit && full && (is_ld || is_st));
    e_regd_wr = e_en && e_commit && (m_zone == ex_pkg::zone_regfile);
    e_lq_wr   = e_en && e_commit && is_ld;
    e_sq_wr   = e_en && e_commit && is_st;
    e_jump    = e_en && ((e_commit && m_jump) || e_trap);
    e_cncl    = e_en && m_valid && is_ld && !e_commit;
endtask

// state after the coming rising edge, taken with the inputs driven now
task automatic step_model();
    if (e_en) begin
        if (e_jump) begin
            m_run = 1'b0;
        end else if (!m_run && ids_valid_i && ids_sofid_i == ex_pkg::sofid_jump) begin
            m_run = 1'b1;
        end
        m_valid     = ids_valid_i;
        m_zone      = ids_zone_i;
        m_cond      = ids_cond_i;
        m_jump      = ids_jump_i;
        m_link      = ids_link_i;
        m_ecall     = ids_ecall_i;
        m_ferr      = ids_ins_ferr_i;
        m_uerr      = ids_ins_uerr_i;
        m_funct3    = ids_funct3_i;
        m_regd_addr = ids_regd_addr_i;
        m_link_addr = ids_pc_i + {29'd0, ids_ins_size_i, 1'b0};
        m_regs2     = ids_regs2_data_i;
        m_result    = expected_alu(ids_alu_op_i, ids_operand_left_i, ids_operand_right_i);
        m_cmp       = branch_holds(ids_funct3_i, ids_regs1_data_i, ids_cmp_right_i);
    end
endtask

`endif

// ==== tb_ex_stage.sv ====
// testbench for the execute stage with lfsr stimulus, reference model checks and watchdog
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int            num_instr = 3000;
    localparam ex_pkg::xlen_t trap_vec  = 32'h0000_0100;

    logic                clk_i;
    logic                reset_i;
    logic                ids_valid_i;
    ex_pkg::sofid_e      ids_sofid_i;
    logic [1:0]          ids_ins_size_i;
    logic                ids_ins_uerr_i, ids_ins_ferr_i, ids_jump_i;
    logic                ids_ecall_i, ids_cond_i, ids_link_i;
    ex_pkg::zone_e       ids_zone_i;
    ex_pkg::xlen_t       ids_pc_i;
    ex_pkg::alu_op_e     ids_alu_op_i;
    ex_pkg::xlen_t       ids_operand_left_i, ids_operand_right_i;
    ex_pkg::xlen_t       ids_regs1_data_i, ids_cmp_right_i, ids_regs2_data_i;
    ex_pkg::regaddr_t    ids_regd_addr_i;
    ex_pkg::funct3_t     ids_funct3_i;
    logic                lsq_full_i;
    logic                pfu_jump_o;
    ex_pkg::xlen_t       pfu_jump_addr_o;
    logic                ids_stall_o, ids_regd_wr_o, ids_regd_cncl_load_o;
    ex_pkg::regaddr_t    ids_regd_addr_o, lsq_regd_addr_o;
    ex_pkg::xlen_t       ids_regd_data_o, lsq_regs2_data_o, lsq_addr_o;
    logic                lsq_lq_wr_o, lsq_sq_wr_o;
    ex_pkg::funct3_t     lsq_funct3_o;
    logic                trap_o;
    ex_pkg::trap_cause_e trap_cause_o;

    int   n_checks = 0;
    int   n_errors = 0;
    int   n_issued = 0;
    int   n_traps  = 0;
    int   n_stalls = 0;
    logic stall_seen  = 1'b0;
    logic sof_pending = 1'b0;

    ex_stage_top #(
        .TRAP_VEC       (trap_vec),
        .HAS_COMPRESSED (1'b0)
    ) dut0 (.*);

    `include "tb_ex_model.svh"

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //--------------------------------------------------------------------------
    // compare tasks
    //--------------------------------------------------------------------------
    task automatic check_word(input string name, input ex_pkg::xlen_t exp,
                              input ex_pkg::xlen_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_cause(input string name, input ex_pkg::trap_cause_e exp,
                               input ex_pkg::trap_cause_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    //--------------------------------------------------------------------------
    // stimulus
    //--------------------------------------------------------------------------
    task automatic draw_instr();
        ex_pkg::xlen_t left;
        ex_pkg::xlen_t right;
        logic [2:0]    cmp_a;
        logic [2:0]    cmp_b;
        logic          valid;
        left  = take_bits(32);
        right = take_bits(32);
        cmp_a = 3'(take_bits(3));
        cmp_b = 3'(take_bits(3));
        valid = (take_bits(3) != 0);
        // three in four operands aligned, so most accesses and targets pass
        if (take_bits(2) != 0) begin
            left[1:0] = 2'b00;
        end
        if (take_bits(2) != 0) begin
            right[1:0] = 2'b00;
        end
        ids_valid_i         <= valid;
        ids_sofid_i         <= (valid && sof_pending) ? ex_pkg::sofid_jump : ex_pkg::sofid_run;
        if (valid) begin
            sof_pending = 1'b0;
        end
        ids_ins_size_i      <= 2'(take_bits(2));
        ids_ins_uerr_i      <= (take_bits(5) == 0);
        ids_ins_ferr_i      <= (take_bits(5) == 0);
        ids_ecall_i         <= (take_bits(5) == 0);
        ids_jump_i          <= (take_bits(2) == 0);
        ids_cond_i          <= (take_bits(1) != 0);
        ids_link_i          <= (take_bits(2) == 0);
        ids_zone_i          <= ex_pkg::zone_e'(2'(take_bits(2)));
        ids_pc_i            <= take_bits(30) << 2;
        ids_alu_op_i        <= ex_pkg::alu_op_e'(4'(take_bits(4) % 10));
        ids_operand_left_i  <= left;
        ids_operand_right_i <= right;
        // small signed compare operands so branches hold often
        ids_regs1_data_i    <= {{29{cmp_a[2]}}, cmp_a};
        ids_cmp_right_i     <= {{29{cmp_b[2]}}, cmp_b};
        ids_regs2_data_i    <= take_bits(32);
        ids_regd_addr_i     <= 5'(take_bits(5));
        ids_funct3_i        <= 3'(take_bits(3));
    endtask

    initial begin
        reset_i             = 1'b1;
        lsq_full_i          = 1'b0;
        ids_valid_i         = 1'b0;
        ids_sofid_i         = ex_pkg::sofid_run;
        ids_ins_size_i      = 2'd2;
        ids_ins_uerr_i      = 1'b0;
        ids_ins_ferr_i      = 1'b0;
        ids_jump_i          = 1'b0;
        ids_ecall_i         = 1'b0;
        ids_cond_i          = 1'b0;
        ids_link_i          = 1'b0;
        ids_zone_i          = ex_pkg::zone_none;
        ids_pc_i            = '0;
        ids_alu_op_i        = ex_pkg::alu_add;
        ids_operand_left_i  = '0;
        ids_operand_right_i = '0;
        ids_regs1_data_i    = '0;
        ids_cmp_right_i     = '0;
        ids_regs2_data_i    = '0;
        ids_regd_addr_i     = '0;
        ids_funct3_i        = '0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        while (n_issued < num_instr) begin
            @(posedge clk_i);
            lsq_full_i <= (take_bits(2) == 0);
            if (!stall_seen) begin
                draw_instr();
                n_issued++;
            end
        end
        // drain the last instruction with the queue open
        lsq_full_i <= 1'b0;
        repeat (3) begin
            @(posedge clk_i);
            if (!stall_seen) begin
                ids_valid_i <= 1'b0;
            end
        end
        if (n_traps == 0 || n_stalls == 0) begin
            n_errors++;
            $display("the random run raised no trap or no stall");
        end
        $display("checks %0d, errors %0d, traps %0d, stalls %0d",
                 n_checks, n_errors, n_traps, n_stalls);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    //--------------------------------------------------------------------------
    // checks against the model, outputs are settled at the falling edge
    //--------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (reset_i) begin
            m_valid    = 1'b0;
            m_run      = 1'b1;
            stall_seen = 1'b0;
        end else begin
            predict_outputs(lsq_full_i);
            check_bit("stall", !e_en, ids_stall_o);
            check_bit("regd_wr", e_regd_wr, ids_regd_wr_o);
            check_bit("cncl_load", e_cncl, ids_regd_cncl_load_o);
            check_bit("lq_wr", e_lq_wr, lsq_lq_wr_o);
            check_bit("sq_wr", e_sq_wr, lsq_sq_wr_o);
            check_bit("pfu_jump", e_jump, pfu_jump_o);
            check_bit("trap", e_en && e_trap, trap_o);
            if (e_regd_wr) begin
                check_word("regd_data", m_link ? m_link_addr : m_result, ids_regd_data_o);
                check_word("regd_addr", 32'(m_regd_addr), 32'(ids_regd_addr_o));
            end
            if (e_lq_wr || e_sq_wr) begin
                check_word("lsq_addr", m_result, lsq_addr_o);
                check_word("lsq_regs2_data", m_regs2, lsq_regs2_data_o);
                check_word("lsq_regd_addr", 32'(m_regd_addr), 32'(lsq_regd_addr_o));
                check_word("lsq_funct3", 32'(m_funct3), 32'(lsq_funct3_o));
            end
            if (e_jump) begin
                check_word("jump_addr", e_trap ? trap_vec : m_result, pfu_jump_addr_o);
            end
            if (e_trap) begin
                check_cause("trap_cause", e_cause, trap_cause_o);
                n_traps++;
            end
            if (ids_stall_o) begin
                n_stalls++;
            end
            // next valid instruction opens the new flow
            if (pfu_jump_o) begin
                sof_pending = 1'b1;
            end
            stall_seen = ids_stall_o;
            step_model();
        end
    end

    // four cycles per instruction leaves room for stalls and the drain
    initial begin
        #(4 * num_instr * 4);
        $display("timeout: the run did not finish within %0d cycles", 4 * num_instr);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
ex_pkg.sv
ex_op_if.sv
ex_alu.sv
ex_issue_reg.sv
ex_commit_ctrl.sv
ex_stage_top.sv
tb_ex_stage.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module tb_ex_stage -f filelist.f -o tb_ex_stage
	./obj_dir/tb_ex_stage > sim.log 2>&1; cat sim.log
	@! grep -q "Test FAILED" sim.log
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
